// File: Makefile
VERILATOR  ?= verilator
TOP        := sim_harness_tb
RTL_TOP    := sim_harness
FILELIST   := sim_harness.f
OBJDIR     := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall
PASS_MSG   := RESULT: PASS

SRCS := $(shell grep '\.sv$$' $(FILELIST)) include/harness_cfg.svh
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: include/harness_cfg.svh
//##########################################################################
// Harness configuration
// Widths, memory size and latency, host register map and the preload
// pattern shared by the memory-side harness
//##########################################################################

`ifndef HARNESS_CFG_SVH
`define HARNESS_CFG_SVH

`define HARNESS_ADDR_W          16
`define HARNESS_DATA_W          32

// 256 words of backing memory at the bottom of the map
`define HARNESS_MEM_DEPTH_LOG2  8
`define HARNESS_MEM_LATENCY     3

`define HARNESS_HOST_FINISH     16'hF000
`define HARNESS_HOST_PUTCHAR    16'hF001
`define HARNESS_HOST_SCRATCH    16'hF002

`define HARNESS_LOAD_WORDS      16
`define HARNESS_LOAD_TAG        16'hA5A5

`endif

// File: sim_harness.f
+incdir+include
source/harness_pkg.sv
source/harness_ctrl.sv
source/mem_model.sv
source/io_host.sv
source/nbf_loader.sv
source/sim_harness.sv
verif/sim_harness_tb.sv

// File: source/harness_ctrl.sv
//##########################################################################
// Harness controller
// Sequences preload then run, routes each command to memory or host by
// address and steers responses back to the port that owns the phase
//##########################################################################

`timescale 1ns/1ps
`include "harness_cfg.svh"

module harness_ctrl
   import harness_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   // Processor port
   input  logic    cmd_v_i,
   input  mem_op_e cmd_op_i,
   input  addr_t   cmd_addr_i,
   input  data_t   cmd_data_i,
   output logic    cmd_ready_o,
   output logic    resp_v_o,
   output data_t   resp_data_o,
   output logic    resp_err_o,
   input  logic    resp_yumi_i,
   // Preload port
   input  logic    ld_cmd_v_i,
   input  mem_op_e ld_cmd_op_i,
   input  addr_t   ld_cmd_addr_i,
   input  data_t   ld_cmd_data_i,
   output logic    ld_cmd_ready_o,
   output logic    ld_resp_v_o,
   input  logic    ld_done_i,
   // Memory
   output logic    mem_cmd_v_o,
   output mem_op_e mem_cmd_op_o,
   output addr_t   mem_cmd_addr_o,
   output data_t   mem_cmd_data_o,
   input  logic    mem_cmd_ready_i,
   input  logic    mem_resp_v_i,
   input  data_t   mem_resp_data_i,
   output logic    mem_resp_yumi_o,
   input  logic    mem_busy_i,
   // Host
   output logic    host_cmd_v_o,
   output mem_op_e host_cmd_op_o,
   output addr_t   host_cmd_addr_o,
   output data_t   host_cmd_data_o,
   input  logic    host_cmd_ready_i,
   input  logic    host_resp_v_i,
   input  data_t   host_resp_data_i,
   input  logic    host_resp_err_i,
   output logic    host_resp_yumi_o
);

   harness_state_e state_q;
   harness_state_e state_d;
   logic    in_load;
   logic    in_run;
   logic    src_v;
   mem_op_e src_op;
   addr_t   src_addr;
   data_t   src_data;
   logic    to_mem;
   logic    mem_open;
   logic    host_open;
   logic    src_ready;
   logic    any_resp_v;
   logic    owner_yumi;

   always_comb begin
      state_d = state_q;
      case (state_q)
         e_st_reset: state_d = e_st_load;
         e_st_load: begin
            if (ld_done_i) begin
               state_d = e_st_run;
            end
         end
         e_st_run:   state_d = e_st_run;
         default:    state_d = e_st_reset;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= e_st_reset;
      end else begin
         state_q <= state_d;
      end
   end

   assign in_load = (state_q == e_st_load);
   assign in_run  = (state_q == e_st_run);

   // Phase owner drives the shared command path
   always_comb begin
      src_v    = 1'b0;
      src_op   = cmd_op_i;
      src_addr = cmd_addr_i;
      src_data = cmd_data_i;
      if (in_load) begin
         src_v    = ld_cmd_v_i;
         src_op   = ld_cmd_op_i;
         src_addr = ld_cmd_addr_i;
         src_data = ld_cmd_data_i;
      end else if (in_run) begin
         src_v = cmd_v_i;
      end
   end

   assign to_mem = (src_addr[`HARNESS_ADDR_W-1:`HARNESS_MEM_DEPTH_LOG2] == '0);

   // Host only behind an empty memory pipe, memory only behind an idle host
   assign mem_open  = !host_resp_v_i;
   assign host_open = !mem_busy_i;

   assign mem_cmd_v_o     = src_v && to_mem && mem_open;
   assign mem_cmd_op_o    = src_op;
   assign mem_cmd_addr_o  = src_addr;
   assign mem_cmd_data_o  = src_data;
   assign host_cmd_v_o    = src_v && !to_mem && host_open;
   assign host_cmd_op_o   = src_op;
   assign host_cmd_addr_o = src_addr;
   assign host_cmd_data_o = src_data;

   assign src_ready      = to_mem ? (mem_cmd_ready_i && mem_open)
                                  : (host_cmd_ready_i && host_open);
   assign cmd_ready_o    = in_run && src_ready;
   assign ld_cmd_ready_o = in_load && src_ready;

   assign any_resp_v  = mem_resp_v_i || host_resp_v_i;
   assign resp_v_o    = in_run && any_resp_v;
   assign resp_data_o = mem_resp_v_i ? mem_resp_data_i : host_resp_data_i;
   assign resp_err_o  = host_resp_v_i && host_resp_err_i;
   assign ld_resp_v_o = in_load && any_resp_v;

   // Loader acks are drained right away
   assign owner_yumi       = in_load ? any_resp_v : (in_run && resp_yumi_i);
   assign mem_resp_yumi_o  = mem_resp_v_i && owner_yumi;
   assign host_resp_yumi_o = host_resp_v_i && owner_yumi;

   a_one_resp_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(mem_resp_v_i && host_resp_v_i));

endmodule

// File: source/harness_pkg.sv
//##########################################################################
// Harness types
// Command opcodes, controller phases and the address and data words
//##########################################################################

`include "harness_cfg.svh"

package harness_pkg;

   typedef enum logic [1:0] {
      e_op_read  = 2'd0,
      e_op_write = 2'd1
   } mem_op_e;

   typedef enum logic [1:0] {
      e_st_reset = 2'd0,
      e_st_load  = 2'd1,
      e_st_run   = 2'd2
   } harness_state_e;

   typedef logic [`HARNESS_ADDR_W-1:0] addr_t;
   typedef logic [`HARNESS_DATA_W-1:0] data_t;

endpackage

// File: source/io_host.sv
//##########################################################################
// Host device
// Finish, character output and scratch registers, one response held at
// a time and returned one cycle after the command
//##########################################################################

`timescale 1ns/1ps
`include "harness_cfg.svh"

module io_host
   import harness_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       cmd_v_i,
   input  mem_op_e    cmd_op_i,
   input  addr_t      cmd_addr_i,
   input  data_t      cmd_data_i,
   output logic       cmd_ready_o,
   output logic       resp_v_o,
   output data_t      resp_data_o,
   output logic       resp_err_o,
   input  logic       resp_yumi_i,
   output logic       finish_o,
   output logic       putchar_v_o,
   output logic [7:0] putchar_data_o
);

   logic       accept;
   logic       is_wr;
   logic       hit_finish;
   logic       hit_putchar;
   logic       hit_scratch;
   logic       resp_v_q;
   data_t      resp_data_q;
   logic       resp_err_q;
   logic       finish_q;
   logic       putchar_v_q;
   logic [7:0] putchar_data_q;
   data_t      scratch_q;
   data_t      nxt_data;
   logic       nxt_err;

   assign cmd_ready_o = !resp_v_q || resp_yumi_i;
   assign accept      = cmd_v_i && cmd_ready_o;
   assign is_wr       = (cmd_op_i == e_op_write);
   assign hit_finish  = (cmd_addr_i == `HARNESS_HOST_FINISH);
   assign hit_putchar = (cmd_addr_i == `HARNESS_HOST_PUTCHAR);
   assign hit_scratch = (cmd_addr_i == `HARNESS_HOST_SCRATCH);

   always_comb begin
      nxt_data = '0;
      nxt_err  = !(hit_finish || hit_putchar || hit_scratch);
      if (!is_wr && hit_finish) begin
         nxt_data = data_t'(finish_q);
      end else if (!is_wr && hit_scratch) begin
         nxt_data = scratch_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         resp_v_q    <= 1'b0;
         finish_q    <= 1'b0;
         putchar_v_q <= 1'b0;
      end else begin
         putchar_v_q <= accept && is_wr && hit_putchar;
         // Sticky until reset
         if (accept && is_wr && hit_finish) begin
            finish_q <= 1'b1;
         end
         if (accept) begin
            resp_v_q <= 1'b1;
         end else if (resp_yumi_i) begin
            resp_v_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         resp_data_q <= nxt_data;
         resp_err_q  <= nxt_err;
      end
      if (accept && is_wr && hit_scratch) begin
         scratch_q <= cmd_data_i;
      end
      if (accept && is_wr && hit_putchar) begin
         putchar_data_q <= cmd_data_i[7:0];
      end
   end

   assign resp_v_o       = resp_v_q;
   assign resp_data_o    = resp_data_q;
   assign resp_err_o     = resp_err_q;
   assign finish_o       = finish_q;
   assign putchar_v_o    = putchar_v_q;
   assign putchar_data_o = putchar_data_q;

endmodule

// File: source/mem_model.sv
//##########################################################################
// Memory model
// Word memory behind a fixed-latency response pipeline, several requests
// in flight, the whole pipe freezing while its head response waits
//##########################################################################

`timescale 1ns/1ps
`include "harness_cfg.svh"

module mem_model
   import harness_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  logic    cmd_v_i,
   input  mem_op_e cmd_op_i,
   input  addr_t   cmd_addr_i,
   input  data_t   cmd_data_i,
   output logic    cmd_ready_o,
   output logic    resp_v_o,
   output data_t   resp_data_o,
   input  logic    resp_yumi_i,
   output logic    busy_o
);

   localparam int DEPTH = 1 << `HARNESS_MEM_DEPTH_LOG2;
   localparam int LAT   = `HARNESS_MEM_LATENCY;

   data_t mem_q [DEPTH];
   logic [LAT-1:0] pipe_v_q;
   data_t pipe_data_q [LAT];
   logic [`HARNESS_MEM_DEPTH_LOG2-1:0] word_idx;
   logic  advance;
   logic  accept;
   logic  is_wr;
   data_t rd_data;

   assign word_idx = cmd_addr_i[`HARNESS_MEM_DEPTH_LOG2-1:0];
   assign is_wr    = (cmd_op_i == e_op_write);

   // Head empty or leaving this cycle
   assign advance     = !pipe_v_q[LAT-1] || resp_yumi_i;
   assign cmd_ready_o = advance;
   assign accept      = cmd_v_i && cmd_ready_o;

   // Write acks carry zero data
   assign rd_data = is_wr ? '0 : mem_q[word_idx];

   always_ff @(posedge clk_i) begin
      if (accept && is_wr) begin
         mem_q[word_idx] <= cmd_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pipe_v_q <= '0;
      end else if (advance) begin
         pipe_v_q <= {pipe_v_q[LAT-2:0], accept};
      end
   end

   always_ff @(posedge clk_i) begin
      if (advance) begin
         pipe_data_q[0] <= rd_data;
         for (int i = 1; i < LAT; i++) begin
            pipe_data_q[i] <= pipe_data_q[i-1];
         end
      end
   end

   assign resp_v_o    = pipe_v_q[LAT-1];
   assign resp_data_o = pipe_data_q[LAT-1];
   assign busy_o      = |pipe_v_q;

   // A command offered into a stall is not taken and still waits unchanged
   property p_stall_holds;
      @(posedge clk_i) disable iff (!rst_n_i)
      (resp_v_o && !resp_yumi_i && cmd_v_i) |=>
         (cmd_v_i && $stable(cmd_op_i) && $stable(cmd_addr_i) && $stable(cmd_data_i));
   endproperty

   a_stall_holds: assert property (p_stall_holds);

endmodule

// File: source/nbf_loader.sv
//##########################################################################
// Preload engine
// Writes the tagged index pattern into the bottom of memory, one word
// per accepted cycle, and flags done once every write is acknowledged
//##########################################################################

`timescale 1ns/1ps
`include "harness_cfg.svh"

module nbf_loader
   import harness_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   output logic    cmd_v_o,
   output mem_op_e cmd_op_o,
   output addr_t   cmd_addr_o,
   output data_t   cmd_data_o,
   input  logic    cmd_ready_i,
   input  logic    resp_v_i,
   output logic    done_o
);

   localparam int CNT_W = $clog2(`HARNESS_LOAD_WORDS + 1);
   localparam logic [CNT_W-1:0] TOTAL = CNT_W'(`HARNESS_LOAD_WORDS);

   logic [CNT_W-1:0] issue_cnt_q;
   logic [CNT_W-1:0] ack_cnt_q;

   assign cmd_v_o    = (issue_cnt_q != TOTAL);
   assign cmd_op_o   = e_op_write;
   assign cmd_addr_o = addr_t'(issue_cnt_q);
   // Tag above, word index below
   assign cmd_data_o = {`HARNESS_LOAD_TAG, (`HARNESS_DATA_W-16)'(issue_cnt_q)};

   assign done_o = (issue_cnt_q == TOTAL) && (ack_cnt_q == TOTAL);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         issue_cnt_q <= '0;
         ack_cnt_q   <= '0;
      end else begin
         if (cmd_v_o && cmd_ready_i) begin
            issue_cnt_q <= issue_cnt_q + 1'b1;
         end
         if (resp_v_i) begin
            ack_cnt_q <= ack_cnt_q + 1'b1;
         end
      end
   end

   // Once done the loader stays quiet for good
   a_quiet_after_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      done_o |=> (done_o && !cmd_v_o));

endmodule

// File: source/sim_harness.sv
//##########################################################################
// Simulation harness top
// Processor-facing command port in front of the controller, memory
// model, host device and preload engine
//##########################################################################

`timescale 1ns/1ps

module sim_harness
   import harness_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       cmd_v_i,
   input  mem_op_e    cmd_op_i,
   input  addr_t      cmd_addr_i,
   input  data_t      cmd_data_i,
   output logic       cmd_ready_o,
   output logic       resp_v_o,
   output data_t      resp_data_o,
   output logic       resp_err_o,
   input  logic       resp_yumi_i,
   output logic       finish_o,
   output logic       putchar_v_o,
   output logic [7:0] putchar_data_o
);

   logic    ld_cmd_v;
   mem_op_e ld_cmd_op;
   addr_t   ld_cmd_addr;
   data_t   ld_cmd_data;
   logic    ld_cmd_ready;
   logic    ld_resp_v;
   logic    ld_done;

   logic    mem_cmd_v;
   mem_op_e mem_cmd_op;
   addr_t   mem_cmd_addr;
   data_t   mem_cmd_data;
   logic    mem_cmd_ready;
   logic    mem_resp_v;
   data_t   mem_resp_data;
   logic    mem_resp_yumi;
   logic    mem_busy;

   logic    host_cmd_v;
   mem_op_e host_cmd_op;
   addr_t   host_cmd_addr;
   data_t   host_cmd_data;
   logic    host_cmd_ready;
   logic    host_resp_v;
   data_t   host_resp_data;
   logic    host_resp_err;
   logic    host_resp_yumi;

   harness_ctrl ctrl (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .cmd_v_i(cmd_v_i), .cmd_op_i(cmd_op_i), .cmd_addr_i(cmd_addr_i),
      .cmd_data_i(cmd_data_i), .cmd_ready_o(cmd_ready_o),
      .resp_v_o(resp_v_o), .resp_data_o(resp_data_o), .resp_err_o(resp_err_o),
      .resp_yumi_i(resp_yumi_i),
      .ld_cmd_v_i(ld_cmd_v), .ld_cmd_op_i(ld_cmd_op), .ld_cmd_addr_i(ld_cmd_addr),
      .ld_cmd_data_i(ld_cmd_data), .ld_cmd_ready_o(ld_cmd_ready),
      .ld_resp_v_o(ld_resp_v), .ld_done_i(ld_done),
      .mem_cmd_v_o(mem_cmd_v), .mem_cmd_op_o(mem_cmd_op), .mem_cmd_addr_o(mem_cmd_addr),
      .mem_cmd_data_o(mem_cmd_data), .mem_cmd_ready_i(mem_cmd_ready),
      .mem_resp_v_i(mem_resp_v), .mem_resp_data_i(mem_resp_data),
      .mem_resp_yumi_o(mem_resp_yumi), .mem_busy_i(mem_busy),
      .host_cmd_v_o(host_cmd_v), .host_cmd_op_o(host_cmd_op),
      .host_cmd_addr_o(host_cmd_addr), .host_cmd_data_o(host_cmd_data),
      .host_cmd_ready_i(host_cmd_ready),
      .host_resp_v_i(host_resp_v), .host_resp_data_i(host_resp_data),
      .host_resp_err_i(host_resp_err), .host_resp_yumi_o(host_resp_yumi)
   );

   mem_model mem (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .cmd_v_i(mem_cmd_v), .cmd_op_i(mem_cmd_op), .cmd_addr_i(mem_cmd_addr),
      .cmd_data_i(mem_cmd_data), .cmd_ready_o(mem_cmd_ready),
      .resp_v_o(mem_resp_v), .resp_data_o(mem_resp_data),
      .resp_yumi_i(mem_resp_yumi), .busy_o(mem_busy)
   );

   io_host host (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .cmd_v_i(host_cmd_v), .cmd_op_i(host_cmd_op), .cmd_addr_i(host_cmd_addr),
      .cmd_data_i(host_cmd_data), .cmd_ready_o(host_cmd_ready),
      .resp_v_o(host_resp_v), .resp_data_o(host_resp_data),
      .resp_err_o(host_resp_err), .resp_yumi_i(host_resp_yumi),
      .finish_o(finish_o), .putchar_v_o(putchar_v_o),
      .putchar_data_o(putchar_data_o)
   );

   nbf_loader loader (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .cmd_v_o(ld_cmd_v), .cmd_op_o(ld_cmd_op), .cmd_addr_o(ld_cmd_addr),
      .cmd_data_o(ld_cmd_data), .cmd_ready_i(ld_cmd_ready),
      .resp_v_i(ld_resp_v), .done_o(ld_done)
   );

endmodule

// File: verif/sim_harness_tb.sv
//##########################################################################
// Harness testbench
// Plays the processor against the harness top with a table of commands
// and expected responses, random response back-pressure and side checks
//##########################################################################

`timescale 1ns/1ps
`include "harness_cfg.svh"

module sim_harness_tb
   import harness_pkg::*;
();

   localparam int          MAX_ROWS   = 64;
   localparam int          ROW_CYCLES = 40;
   localparam int          SLACK      = 200;
   localparam logic [15:0] LFSR_SEED  = 16'd16;
   localparam logic [15:0] LFSR_TAPS  = 16'hB400;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        cmd_v;
   mem_op_e     cmd_op;
   addr_t       cmd_addr;
   data_t       cmd_data;
   logic        cmd_ready;
   logic        resp_v;
   data_t       resp_data;
   logic        resp_err;
   logic        resp_yumi;
   logic        finish;
   logic        putchar_v;
   logic [7:0]  putchar_data;

   // Command table
   mem_op_e t_op    [MAX_ROWS];
   addr_t   t_addr  [MAX_ROWS];
   data_t   t_wdata [MAX_ROWS];
   data_t   t_exp   [MAX_ROWS];
   logic    t_err   [MAX_ROWS];
   logic    t_burst [MAX_ROWS];
   int      t_lat   [MAX_ROWS];
   int      n_rows = 0;
   logic    table_ready = 1'b0;

   // Responses still owed, oldest first
   data_t exp_data_q [$];
   logic  exp_err_q  [$];
   int    exp_lat_q  [$];
   int    exp_edge_q [$];

   int          n_checks  = 0;
   int          n_errors  = 0;
   int          n_issued  = 0;
   int          n_resp    = 0;
   int          cyc       = 0;
   int          n_chars   = 0;
   int          exp_chars = 0;
   logic [7:0]  last_char;
   logic [7:0]  exp_char;
   logic        fin_exp   = 1'b0;
   logic        resp_seen = 1'b0;
   logic        bp_on     = 1'b1;
   logic [15:0] lfsr      = LFSR_SEED;
   logic        bit_a;
   logic        bit_b;

   sim_harness uut (
      .clk_i(clk), .rst_n_i(rst_n),
      .cmd_v_i(cmd_v), .cmd_op_i(cmd_op), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data),
      .cmd_ready_o(cmd_ready), .resp_v_o(resp_v), .resp_data_o(resp_data),
      .resp_err_o(resp_err), .resp_yumi_i(resp_yumi), .finish_o(finish),
      .putchar_v_o(putchar_v), .putchar_data_o(putchar_data)
   );

   function automatic logic [15:0] next_lfsr(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ LFSR_TAPS;
      end
      return n;
   endfunction

   task automatic add_row(input mem_op_e op, input addr_t addr, input data_t wdata,
                          input data_t exp, input logic err, input logic burst,
                          input int lat);
      t_op[n_rows]    = op;
      t_addr[n_rows]  = addr;
      t_wdata[n_rows] = wdata;
      t_exp[n_rows]   = exp;
      t_err[n_rows]   = err;
      t_burst[n_rows] = burst;
      t_lat[n_rows]   = lat;
      n_rows++;
   endtask

   task automatic build_table();
      // Preloaded words
      for (int a = 0; a < `HARNESS_LOAD_WORDS; a++) begin
         add_row(e_op_read, addr_t'(a), '0, {`HARNESS_LOAD_TAG, 16'(a)}, 1'b0, 1'b0, 0);
      end
      add_row(e_op_write, 16'h0003, 32'h1111_2222, '0, 1'b0, 1'b0, 0);
      add_row(e_op_write, 16'h0080, 32'hDEAD_BEEF, '0, 1'b0, 1'b0, 0);
      add_row(e_op_write, 16'h00FF, 32'h0BAD_F00D, '0, 1'b0, 1'b0, 0);
      add_row(e_op_write, 16'h0003, 32'h3333_4444, '0, 1'b0, 1'b0, 0);
      add_row(e_op_read,  16'h0003, '0, 32'h3333_4444, 1'b0, 1'b0, 0);
      add_row(e_op_read,  16'h0080, '0, 32'hDEAD_BEEF, 1'b0, 1'b0, 0);
      add_row(e_op_read,  16'h00FF, '0, 32'h0BAD_F00D, 1'b0, 1'b0, 0);
      // Back-to-back, only the last row of a burst waits
      for (int a = 0; a < 8; a++) begin
         add_row(e_op_read, addr_t'(a), '0,
                 (a == 3) ? 32'h3333_4444 : {`HARNESS_LOAD_TAG, 16'(a)},
                 1'b0, (a != 7), 0);
      end
      add_row(e_op_write, 16'h0020, 32'h55AA_55AA, '0, 1'b0, 1'b1, 0);
      add_row(e_op_read,  16'h0020, '0, 32'h55AA_55AA, 1'b0, 1'b1, 0);
      add_row(e_op_read,  16'h0080, '0, 32'hDEAD_BEEF, 1'b0, 1'b1, 0);
      add_row(e_op_read,  `HARNESS_HOST_FINISH, '0, '0, 1'b0, 1'b1, 0);
      add_row(e_op_read,  16'h0001, '0, {`HARNESS_LOAD_TAG, 16'h0001}, 1'b0, 1'b0, 0);
      // Host registers
      add_row(e_op_write, `HARNESS_HOST_SCRATCH, 32'hCAFE_F00D, '0, 1'b0, 1'b0, 0);
      add_row(e_op_read,  `HARNESS_HOST_SCRATCH, '0, 32'hCAFE_F00D, 1'b0, 1'b0, 0);
      add_row(e_op_write, `HARNESS_HOST_PUTCHAR, 32'h0000_1241, '0, 1'b0, 1'b0, 0);
      add_row(e_op_read,  `HARNESS_HOST_FINISH, '0, '0, 1'b0, 1'b0, 0);
      add_row(e_op_write, `HARNESS_HOST_FINISH, 32'h0000_0001, '0, 1'b0, 1'b0, 0);
      add_row(e_op_read,  `HARNESS_HOST_FINISH, '0, 32'h0000_0001, 1'b0, 1'b0, 0);
      // Unmapped, then memory must be untouched
      add_row(e_op_read,  16'h0100, '0, '0, 1'b1, 1'b0, 0);
      add_row(e_op_write, 16'h0100, 32'h9999_9999, '0, 1'b1, 1'b0, 0);
      add_row(e_op_write, 16'h01FF, 32'h7777_7777, '0, 1'b1, 1'b0, 0);
      add_row(e_op_read,  16'h8000, '0, '0, 1'b1, 1'b0, 0);
      add_row(e_op_write, 16'hEFFF, 32'h1234_5678, '0, 1'b1, 1'b0, 0);
      add_row(e_op_read,  16'hF003, '0, '0, 1'b1, 1'b0, 0);
      add_row(e_op_write, 16'hFFFF, 32'h8765_4321, '0, 1'b1, 1'b0, 0);
      add_row(e_op_read,  16'h0000, '0, {`HARNESS_LOAD_TAG, 16'h0000}, 1'b0, 1'b0, 0);
      add_row(e_op_read,  16'h00FF, '0, 32'h0BAD_F00D, 1'b0, 1'b0, 0);
      // Latency rows run with no back-pressure
      add_row(e_op_read, `HARNESS_HOST_SCRATCH, '0, 32'hCAFE_F00D, 1'b0, 1'b0, 1);
      add_row(e_op_read, 16'h0080, '0, 32'hDEAD_BEEF, 1'b0, 1'b0, `HARNESS_MEM_LATENCY);
   endtask

   task automatic run_row(input int i);
      bp_on    = (t_lat[i] == 0);
      cmd_v    = 1'b1;
      cmd_op   = t_op[i];
      cmd_addr = t_addr[i];
      cmd_data = t_wdata[i];
      @(negedge clk);
      while (!cmd_ready) begin
         @(negedge clk);
      end
      // Transfer lands on the coming edge
      exp_data_q.push_back(t_exp[i]);
      exp_err_q.push_back(t_err[i]);
      exp_lat_q.push_back(t_lat[i]);
      exp_edge_q.push_back(cyc + 1);
      n_issued++;
      if (t_op[i] == e_op_write && t_addr[i] == `HARNESS_HOST_PUTCHAR) begin
         exp_chars++;
         exp_char = t_wdata[i][7:0];
      end
      if (t_op[i] == e_op_write && t_addr[i] == `HARNESS_HOST_FINISH) begin
         fin_exp = 1'b1;
      end
      @(posedge clk);
      #1;
      cmd_v = 1'b0;
      if (!t_burst[i]) begin
         while (exp_data_q.size() != 0) begin
            @(posedge clk);
            #1;
         end
         n_checks++;
         if (finish !== fin_exp) begin
            $display("FAILED at %0t: row %0d finish_o is %b, expected %b",
                     $time, i, finish, fin_exp);
            n_errors++;
         end
         n_checks++;
         if (n_chars != exp_chars || (exp_chars != 0 && last_char !== exp_char)) begin
            $display("FAILED at %0t: row %0d saw %0d chars last %h, expected %0d last %h",
                     $time, i, n_chars, last_char, exp_chars, exp_char);
            n_errors++;
         end
      end
   endtask

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // Two LFSR bits per cycle, yumi withheld when they differ
   always @(posedge clk) begin
      #1;
      bit_a = lfsr[0];
      lfsr  = next_lfsr(lfsr);
      bit_b = lfsr[0];
      lfsr  = next_lfsr(lfsr);
      resp_yumi = rst_n && resp_v && !(bp_on && (bit_a ^ bit_b));
   end

   always @(negedge clk) begin
      if (rst_n && putchar_v) begin
         n_chars++;
         last_char = putchar_data;
      end
   end

   // Response checker, mid-cycle where everything is settled
   always @(negedge clk) begin
      if (rst_n && resp_v) begin
         if (exp_data_q.size() == 0) begin
            if (resp_yumi) begin
               $display("Response consumed at %0t with no command outstanding", $time);
               n_errors++;
            end
         end else begin
            // Response is sampled on the next edge
            if (!resp_seen && exp_lat_q[0] != 0) begin
               n_checks++;
               if (cyc + 1 - exp_edge_q[0] != exp_lat_q[0]) begin
                  $display("FAILED at %0t: response after %0d cycles, expected %0d",
                           $time, cyc + 1 - exp_edge_q[0], exp_lat_q[0]);
                  n_errors++;
               end
            end
            resp_seen = 1'b1;
            if (resp_yumi) begin
               n_checks++;
               if (resp_data !== exp_data_q[0] || resp_err !== exp_err_q[0]) begin
                  $display("FAILED at %0t: response %h err %b, expected %h err %b",
                           $time, resp_data, resp_err, exp_data_q[0], exp_err_q[0]);
                  n_errors++;
               end
               void'(exp_data_q.pop_front());
               void'(exp_err_q.pop_front());
               void'(exp_lat_q.pop_front());
               void'(exp_edge_q.pop_front());
               n_resp++;
               resp_seen = 1'b0;
            end
         end
      end
   end

   initial begin
      rst_n     = 1'b0;
      cmd_v     = 1'b0;
      cmd_op    = e_op_read;
      cmd_addr  = '0;
      cmd_data  = '0;
      resp_yumi = 1'b0;
      last_char = '0;
      exp_char  = '0;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      n_checks++;
      if (cmd_ready !== 1'b0 || resp_v !== 1'b0 || finish !== 1'b0 || putchar_v !== 1'b0) begin
         $display("FAILED at %0t: outputs not low after reset", $time);
         n_errors++;
      end
      // Load phase is over once the port first opens
      while (!cmd_ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      for (int i = 0; i < n_rows; i++) begin
         run_row(i);
      end
      n_checks++;
      if (n_issued != n_resp) begin
         $display("Responses lost: %0d commands issued but %0d responses returned",
                  n_issued, n_resp);
         n_errors++;
      end
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      wait (table_ready);
      repeat (n_rows * ROW_CYCLES + SLACK) @(posedge clk);
      $display("Timeout: the run did not complete within %0d cycles",
               n_rows * ROW_CYCLES + SLACK);
      n_errors++;
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule
